// File: Makefile
# Verilator build and run for the VDP register block testbench

TOP = vdp_register_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -f vdp_regs.f --top-module $(TOP) \
		-o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/vdp_register_assertions.sv
// VDP register block timing properties
// Ack follows each strobe by one clock, clear pulses last one clock
`timescale 1ns/10ps

module vdp_register_assertions import vdp_pkg::*; (
  input logic     reset,
  input logic     clk21m,
  input cpu_req_t cpu,
  input logic     ack,
  input logic     clr_vsync_int,
  input logic     clr_hsync_int
);

  ack_after_strobe: assert property (@(posedge reset) disable iff (clk21m)
    cpu.strobe |=> ack) else $error("ack did not follow strobe");

  no_ack_without_strobe: assert property (@(posedge reset) disable iff (clk21m)
    !cpu.strobe |=> !ack) else $error("ack without preceding strobe");

  vclr_one_cycle: assert property (@(posedge reset) disable iff (clk21m)
    clr_vsync_int |=> !clr_vsync_int) else $error("frame clear longer than one cycle");

  hclr_one_cycle: assert property (@(posedge reset) disable iff (clk21m)
    clr_hsync_int |=> !clr_hsync_int) else $error("line clear longer than one cycle");

endmodule

bind vdp_register_top vdp_register_assertions u_assertions (
  .reset(reset), .clk21m(clk21m), .cpu(cpu), .ack(ack),
  .clr_vsync_int(clr_vsync_int), .clr_hsync_int(clr_hsync_int)
);

// File: sim/vdp_register_stim.txt
# kind arg data expect (hex). 0 write port=arg, 1 read port=arg, 2 hsync, 3 regs field arg,
# 4 vram field arg, 5 palette idx=data, 6 status inputs=data, 7 clears vs/hs, 8 req flips, 9 snapshot
0 1 5A 0
0 1 87 0
3 0 0 5A
0 1 06 0
0 1 80 0
0 1 00 0
0 1 81 0
3 1 0 0
2 0 0 0
3 1 0 3
0 1 12 0
0 1 91 0
0 3 55 0
0 3 44 0
3 3 0 44
7 0 0 1
0 1 91 0
0 1 91 0
0 3 05 0
3 3 0 44
3 0 0 5A
7 0 0 1
0 1 05 0
0 1 8E 0
9 0 0 0
0 1 34 0
0 1 12 0
8 0 0 5
4 0 0 15234
9 0 0 0
0 0 A7 0
8 0 0 2
4 1 0 A7
0 1 03 0
0 1 90 0
0 2 52 0
0 2 04 0
0 2 17 0
0 2 06 0
5 0 3 162
5 0 4 77
5 0 0 0
6 0 1F 0
0 1 00 0
0 1 8F 0
1 1 0 80
7 0 1 1
0 1 01 0
0 1 8F 0
1 1 0 5
7 0 1 2
0 1 02 0
0 1 8F 0
1 1 0 6E
0 1 03 0
0 1 8F 0
1 1 0 FF
1 0 0 C3
0 1 20 0
0 1 93 0
3 3 0 20
7 0 1 3

// File: sim/vdp_register_tb.sv
// VDP register block testbench
// Replays the stimulus file against the DUT and checks the results
`timescale 1ns/10ps
`include "vdp_defines.svh"

module vdp_register_tb import vdp_pkg::*; ();

  logic       reset;          // Clock
  logic       clk21m;         // Reset, active high
  cpu_req_t   cpu;
  logic       ack;
  logic [7:0] rd_data;
  vram_ctrl_t vram;
  logic       vram_wr_ack, vram_rd_ack, vram_addr_set_ack;
  logic [7:0] vram_rd_data;
  logic       hsync;
  logic [1:0] dotstate;
  logic [3:0] pal_rd_idx;
  pal_rgb_t   pal_rgb;
  ctrl_regs_t regs;
  logic       vsync_int_pending, hsync_int_pending;
  logic       vert_retrace, horz_retrace, field;
  logic       clr_vsync_int, clr_hsync_int;

  logic [2:0] wr_dly, rd_dly, as_dly;
  logic [2:0] snap;           // Request bits at last snapshot
  int         mismatches;
  int         other_errs;
  int         vclr_cnt;
  int         hclr_cnt;
  int         cycles;
  int         cycle_limit;
  logic [31:0] st_kind [$];
  logic [31:0] st_arg [$];
  logic [31:0] st_data [$];
  logic [31:0] st_exp [$];

  vdp_register_top u_dut (.*);

  initial begin
    reset = 1'b0;
    forever #5 reset = ~reset;
  end

  // ------------------------------------------------
  // Environment models
  always @(posedge reset) begin
    wr_dly            <= {wr_dly[1:0], vram.wr_req};
    rd_dly            <= {rd_dly[1:0], vram.rd_req};
    as_dly            <= {as_dly[1:0], vram.addr_set_req};
    vram_wr_ack       <= wr_dly[2];   // Ack four cycles after request
    vram_rd_ack       <= rd_dly[2];
    vram_addr_set_ack <= as_dly[2];
    dotstate          <= dotstate + 2'd1;
  end

  always @(posedge reset) begin
    if (!clk21m) begin
      if (clr_vsync_int) vclr_cnt++;
      if (clr_hsync_int) hclr_cnt++;
    end
  end

  // Watchdog
  always @(posedge reset) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Run exceeded %0d cycles without finishing", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    mismatches++;
    $display("Mismatch %s: got %0h expected %0h at %0t", name, got, exp, $time);
  endtask

  task automatic report_failure(input string what);
    other_errs++;
    $display("Error: %s at %0t", what, $time);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge reset);
  endtask

  // One CPU access, ack checked on the cycle after the strobe
  task automatic cpu_access(input logic wr, input logic [1:0] port,
                            input logic [7:0] data, output logic [7:0] rdat);
    @(posedge reset);
    cpu <= '{1'b1, wr, vdp_port_e'(port), data};
    @(posedge reset);
    cpu.strobe <= 1'b0;
    #1;
    assert (ack === 1'b1) else report_failure("ack missing one cycle after strobe");
    rdat = rd_data;
    @(posedge reset);
    #1;
    assert (ack === 1'b0) else report_failure("ack held longer than one cycle");
    idle(2);
  endtask

  task automatic load_stim();
    int    fd;
    int    n;
    string line;
    logic [31:0] k, a, d, e;
    fd = $fopen("sim/vdp_register_stim.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open stimulus file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%h %h %h %h", k, a, d, e);
      if (n == 4) begin
        st_kind.push_back(k);
        st_arg.push_back(a);
        st_data.push_back(d);
        st_exp.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_step(input int i);
    logic [7:0] rdat;
    logic [2:0] cur;
    logic [31:0] a, d, e;
    a = st_arg[i];
    d = st_data[i];
    e = st_exp[i];
    cur = {vram.addr_set_req, vram.wr_req, vram.rd_req};
    case (st_kind[i])
      0: cpu_access(1'b1, a[1:0], d[7:0], rdat);
      1: begin
        cpu_access(1'b0, a[1:0], 8'h00, rdat);
        check_val("rd_data", {24'd0, rdat}, e);
      end
      2: begin
        @(posedge reset) hsync <= 1'b1;
        @(posedge reset) hsync <= 1'b0;
        idle(1);
      end
      3: begin
        #1;
        case (a)
          0: check_val("regs.r7_frame_col", {24'd0, regs.r7_frame_col}, e);
          1: check_val("regs.mode", {28'd0, regs.mode}, e);
          2: check_val("regs.r2_name_addr", {25'd0, regs.r2_name_addr}, e);
          4: check_val("regs r0/r1 flags", {26'd0, regs.r0_hint_en, regs.r1_sp_size,
                       regs.r1_sp_zoom, regs.r1_bl_clks, regs.r1_vint_en,
                       regs.r1_disp_on}, e);
          default: check_val("regs.r19_hint_line", {24'd0, regs.r19_hint_line}, e);
        endcase
      end
      4: begin
        #1;
        if (a == 0) check_val("vram.addr", {15'd0, vram.addr}, e);
        else check_val("vram.data", {24'd0, vram.data}, e);
      end
      5: begin
        @(posedge reset) pal_rd_idx <= d[3:0];
        @(posedge reset);
        #1;
        check_val("pal_rgb", {23'd0, pal_rgb}, e);
      end
      6: begin
        @(posedge reset);
        {field, horz_retrace, vert_retrace, hsync_int_pending, vsync_int_pending} <= d[4:0];
        idle(1);
      end
      7: begin
        check_val("clr_vsync_int count", vclr_cnt, d);
        check_val("clr_hsync_int count", hclr_cnt, e);
      end
      8: check_val("vram request flips", {29'd0, cur ^ snap}, e);
      9: snap = cur;
      default: report_failure("unknown step kind in stimulus file");
    endcase
  endtask

  initial begin
    clk21m            = 1'b1;
    cpu               = '0;
    vram_wr_ack       = 1'b0;
    vram_rd_ack       = 1'b0;
    vram_addr_set_ack = 1'b0;
    vram_rd_data      = 8'hC3;
    hsync             = 1'b0;
    dotstate          = 2'd0;
    pal_rd_idx        = '0;
    vsync_int_pending = 1'b0;
    hsync_int_pending = 1'b0;
    vert_retrace      = 1'b0;
    horz_retrace      = 1'b0;
    field             = 1'b0;
    wr_dly            = '0;
    rd_dly            = '0;
    as_dly            = '0;
    snap              = '0;
    mismatches        = 0;
    other_errs        = 0;
    vclr_cnt          = 0;
    hclr_cnt          = 0;
    cycles            = 0;
    cycle_limit       = 100000;

    load_stim();
    cycle_limit = 16 + 20 * st_kind.size() + 50;

    repeat (16) @(posedge reset);
    clk21m <= 1'b0;
    @(posedge reset);
    #1;
    // Idle state after reset
    check_val("ack", {31'd0, ack}, 0);
    check_val("clr_vsync_int", {31'd0, clr_vsync_int}, 0);
    check_val("clr_hsync_int", {31'd0, clr_hsync_int}, 0);
    check_val("vram requests", {29'd0, vram.addr_set_req, vram.wr_req, vram.rd_req}, 0);
    check_val("rd_data", {24'd0, rd_data}, 0);

    for (int i = 0; i < st_kind.size(); i++) run_step(i);
    idle(4);

    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: source/vdp_ctrl_regs.sv
// VDP control register file
// Holds R0, R1, R2, R7 and R19; mode and display-on fields are
// shadowed and copied to the live set on hsync, then decoded
`timescale 1ns/10ps
`include "vdp_defines.svh"

module vdp_ctrl_regs import vdp_pkg::*; (
  input  logic       reset,
  input  logic       clk21m,
  input  reg_wr_t    reg_wr,
  input  logic       hsync,
  output ctrl_regs_t regs
);

  logic       r0_hint_en;
  logic [3:1] r0_mode_sh;
  logic [3:1] r0_mode;
  logic       r1_sp_size;
  logic       r1_sp_zoom;
  logic       r1_bl_clks;
  logic       r1_vint_en;
  logic       r1_disp_on_sh;
  logic       r1_disp_on;
  logic [1:0] r1_mode_sh;     // {M1, M2}
  logic [1:0] r1_mode;
  logic [6:0] r2_name_addr;
  logic [7:0] r7_frame_col;
  logic [7:0] r19_hint_line;
  logic [4:0] mode_key;
  disp_mode_e mode;

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      r0_hint_en    <= 1'b0;
      r0_mode_sh    <= '0;
      r1_sp_size    <= 1'b0;
      r1_sp_zoom    <= 1'b0;
      r1_bl_clks    <= 1'b0;
      r1_vint_en    <= 1'b0;
      r1_disp_on_sh <= 1'b0;
      r1_mode_sh    <= '0;
      r2_name_addr  <= '0;
      r7_frame_col  <= '0;
      r19_hint_line <= '0;
    end else if (reg_wr.valid) begin
      case (reg_wr.num)
        `VDP_REG_R0: begin
          r0_mode_sh <= reg_wr.data[3:1];
          r0_hint_en <= reg_wr.data[4];
        end
        `VDP_REG_R1: begin
          r1_sp_zoom    <= reg_wr.data[0];
          r1_sp_size    <= reg_wr.data[1];
          r1_bl_clks    <= reg_wr.data[2];
          r1_mode_sh    <= reg_wr.data[4:3];
          r1_vint_en    <= reg_wr.data[5];
          r1_disp_on_sh <= reg_wr.data[6];
        end
        `VDP_REG_R2:       r2_name_addr  <= reg_wr.data[6:0];
        `VDP_REG_R7:       r7_frame_col  <= reg_wr.data;
        `VDP_HINT_CLR_REG: r19_hint_line <= reg_wr.data;
        default: ;
      endcase
    end
  end

  // --------------------------------------------------
  // Live mode fields, change only at line start
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      r0_mode    <= '0;
      r1_mode    <= '0;
      r1_disp_on <= 1'b0;
    end else if (hsync) begin
      r0_mode    <= r0_mode_sh;
      r1_mode    <= r1_mode_sh;
      r1_disp_on <= r1_disp_on_sh;
    end
  end

  // Key is {M5, M4, M3, M2, M1}
  assign mode_key = {r0_mode, r1_mode[0], r1_mode[1]};

  always_comb begin
    case (mode_key)
      5'b00000: mode = GRAPHIC1;
      5'b00001: mode = TEXT1;
      5'b00010: mode = MULTI;
      5'b00100: mode = GRAPHIC2;
      5'b00101: mode = TEXT1Q;
      5'b00110: mode = MULTIQ;
      5'b01000: mode = GRAPHIC3;
      5'b01001: mode = TEXT2;
      5'b01100: mode = GRAPHIC4;
      5'b10000: mode = GRAPHIC5;
      5'b10100: mode = GRAPHIC6;
      5'b11100: mode = GRAPHIC7;
      default:  mode = MODE_NONE;   // Undefined combinations
    endcase
  end

  always_comb begin
    regs.r0_hint_en    = r0_hint_en;
    regs.r1_sp_size    = r1_sp_size;
    regs.r1_sp_zoom    = r1_sp_zoom;
    regs.r1_bl_clks    = r1_bl_clks;
    regs.r1_vint_en    = r1_vint_en;
    regs.r1_disp_on    = r1_disp_on;
    regs.r2_name_addr  = r2_name_addr;
    regs.r7_frame_col  = r7_frame_col;
    regs.r19_hint_line = r19_hint_line;
    regs.mode          = mode;
  end

endmodule

// File: source/vdp_defines.svh
// VDP register block constants
// Bus widths, register and status numbers, chip id
`ifndef VDP_DEFINES_SVH
`define VDP_DEFINES_SVH

// Widths
`define VDP_DATA_W        8
`define VDP_REGNUM_W      6
`define VDP_VADDR_W       17
`define VDP_PAL_ENTRIES   16
`define VDP_PAL_IDX_W     4
`define VDP_STATUS_W      4

// Chip id reported in S#1, V9958 style
`define VDP_ID            5'b00010

// Control register numbers
`define VDP_REG_R0        6'd0
`define VDP_REG_R1        6'd1
`define VDP_REG_R2        6'd2
`define VDP_REG_R7        6'd7
`define VDP_REG_R14       6'd14
`define VDP_REG_R15       6'd15
`define VDP_REG_R16       6'd16
`define VDP_R17           6'd17
`define VDP_HINT_CLR_REG  6'd19   // R19, line interrupt

// Status register numbers
`define VDP_S0            4'd0
`define VDP_S1            4'd1
`define VDP_S2            4'd2

`endif

// File: source/vdp_palette.sv
// VDP palette
// Two-byte RGB load with auto-incrementing number from R16, entry
// write committed on odd dot states, 16-entry store, registered read
`timescale 1ns/10ps
`include "vdp_defines.svh"

module vdp_palette import vdp_pkg::*; (
  input  logic                      reset,
  input  logic                      clk21m,
  input  reg_wr_t                   reg_wr,
  input  pal_wr_t                   pal_wr,
  input  logic [1:0]                dotstate,
  input  logic [`VDP_PAL_IDX_W-1:0] pal_rd_idx,
  output pal_rgb_t                  pal_rgb
);

  // Power-on colours, one octal digit per channel {R, G, B}
  localparam logic [8:0] PAL_INIT [`VDP_PAL_ENTRIES] = '{
    9'o000, 9'o000, 9'o161, 9'o373, 9'o117, 9'o237, 9'o511, 9'o267,
    9'o711, 9'o733, 9'o661, 9'o664, 9'o141, 9'o625, 9'o555, 9'o777
  };

  logic [`VDP_PAL_IDX_W-1:0] pal_num;
  logic [`VDP_PAL_IDX_W-1:0] wr_num;
  pal_load_e                 load_state;
  pal_rgb_t                  rgb_in;
  logic                      wr_req;
  logic                      wr_ack;
  logic                      odd_dot;
  pal_rgb_t                  store [`VDP_PAL_ENTRIES];

  assign odd_dot = (dotstate == 2'b01) || (dotstate == 2'b10);

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      pal_num    <= '0;
      wr_num     <= '0;
      load_state <= PAL_RB;
      rgb_in     <= '0;
      wr_req     <= 1'b0;
    end else if (reg_wr.valid && reg_wr.num == `VDP_REG_R16) begin
      pal_num    <= reg_wr.data[3:0];
      load_state <= PAL_RB;
    end else if (pal_wr.strobe) begin
      if (load_state == PAL_RB) begin
        rgb_in.r   <= pal_wr.data[6:4];
        rgb_in.b   <= pal_wr.data[2:0];
        load_state <= PAL_G;
      end else begin
        rgb_in.g   <= pal_wr.data[2:0];
        wr_num     <= pal_num;
        wr_req     <= ~wr_ack;      // Post entry write
        load_state <= PAL_RB;
        pal_num    <= pal_num + 4'd1;
      end
    end
  end

  // --------------------------------------------------
  // Store update, only in the odd dot slots
  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      wr_ack <= 1'b0;
      for (int i = 0; i < `VDP_PAL_ENTRIES; i++) store[i] <= pal_rgb_t'(PAL_INIT[i]);
    end else if (odd_dot && (wr_req != wr_ack)) begin
      store[wr_num] <= rgb_in;
      wr_ack        <= ~wr_ack;
    end
  end

  always_ff @(posedge reset) begin
    pal_rgb <= store[pal_rd_idx];
  end

endmodule

// File: source/vdp_pkg.sv
// VDP register block types
// Port and mode encodings, bus structs between the blocks
`include "vdp_defines.svh"

package vdp_pkg;

  typedef enum logic [1:0] {
    PORT_VRAM     = 2'd0,
    PORT_CTRL     = 2'd1,
    PORT_PAL      = 2'd2,
    PORT_INDIRECT = 2'd3
  } vdp_port_e;

  typedef enum logic [3:0] {
    GRAPHIC1, GRAPHIC2, GRAPHIC3, GRAPHIC4, GRAPHIC5, GRAPHIC6, GRAPHIC7,
    TEXT1, TEXT1Q, TEXT2, MULTI, MULTIQ, MODE_NONE
  } disp_mode_e;

  typedef enum logic {
    PAL_RB = 1'b0,  // Expecting red/blue byte
    PAL_G  = 1'b1
  } pal_load_e;

  typedef struct packed {
    logic                   strobe;
    logic                   wr;
    vdp_port_e              port;
    logic [`VDP_DATA_W-1:0] data;
  } cpu_req_t;

  typedef struct packed {
    logic                     valid;
    logic [`VDP_REGNUM_W-1:0] num;
    logic [`VDP_DATA_W-1:0]   data;
  } reg_wr_t;

  typedef struct packed {
    logic                   strobe;
    logic [`VDP_DATA_W-1:0] data;
  } pal_wr_t;

  typedef struct packed {
    logic [`VDP_VADDR_W-1:0] addr;
    logic [`VDP_DATA_W-1:0]  data;
    logic                    addr_set_req;
    logic                    wr_req;
    logic                    rd_req;
  } vram_ctrl_t;

  typedef struct packed {
    logic       r0_hint_en;
    logic       r1_sp_size;
    logic       r1_sp_zoom;
    logic       r1_bl_clks;
    logic       r1_vint_en;
    logic       r1_disp_on;
    logic [6:0] r2_name_addr;
    logic [7:0] r7_frame_col;
    logic [7:0] r19_hint_line;
    disp_mode_e mode;
  } ctrl_regs_t;

  typedef struct packed {
    logic [2:0] r;
    logic [2:0] g;
    logic [2:0] b;
  } pal_rgb_t;

endpackage

// File: source/vdp_port_ctrl.sv
// VDP CPU port decoder
// Port 1 byte pairing, indirect writes via R17, VRAM address and
// toggle requests, status select (R15) and palette byte forwarding
`timescale 1ns/10ps
`include "vdp_defines.svh"

module vdp_port_ctrl import vdp_pkg::*; (
  input  logic                     reset,
  input  logic                     clk21m,
  input  cpu_req_t                 cpu,
  input  logic                     vram_wr_ack,
  input  logic                     vram_rd_ack,
  input  logic                     vram_addr_set_ack,
  output reg_wr_t                  reg_wr,
  output pal_wr_t                  pal_wr,
  output vram_ctrl_t               vram,
  output logic [`VDP_STATUS_W-1:0] status_sel,
  output logic                     hint_clr_wr
);

  logic                     first_byte;   // Port 1 waiting for first byte
  logic [`VDP_DATA_W-1:0]   p1_data;
  logic [`VDP_REGNUM_W-1:0] reg_ptr;
  logic                     reg_wr_pulse;
  logic [`VDP_REGNUM_W-1:0] r17_num;
  logic                     r17_inc;
  logic                     cpu_rd;
  logic                     cpu_wr;

  assign cpu_rd = cpu.strobe & ~cpu.wr;
  assign cpu_wr = cpu.strobe & cpu.wr;

  assign reg_wr.valid = reg_wr_pulse;
  assign reg_wr.num   = reg_ptr;
  assign reg_wr.data  = p1_data;

  // Palette bytes go straight through, palette tracks its own byte state
  assign pal_wr.strobe = cpu_wr && (cpu.port == PORT_PAL);
  assign pal_wr.data   = cpu.data;

  // R19 write, or R0 write with IE1 set
  assign hint_clr_wr = reg_wr_pulse && (reg_ptr == `VDP_HINT_CLR_REG ||
                       (reg_ptr == `VDP_REG_R0 && p1_data[4]));

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      first_byte        <= 1'b1;
      p1_data           <= '0;
      reg_ptr           <= '0;
      reg_wr_pulse      <= 1'b0;
      r17_num           <= '0;
      r17_inc           <= 1'b0;
      status_sel        <= '0;
      vram.addr         <= '0;
      vram.data         <= '0;
      vram.addr_set_req <= 1'b0;
      vram.wr_req       <= 1'b0;
      vram.rd_req       <= 1'b0;
    end else begin
      reg_wr_pulse <= 1'b0;

      // --------------------------------------------------
      // Registers owned here, applied on the write pulse
      if (reg_wr_pulse) begin
        case (reg_ptr)
          `VDP_REG_R14: begin
            vram.addr[16:14]  <= p1_data[2:0];
            vram.addr_set_req <= ~vram_addr_set_ack;
          end
          `VDP_REG_R15: status_sel <= p1_data[3:0];
          `VDP_R17: begin
            r17_num <= p1_data[5:0];
            r17_inc <= ~p1_data[7];   // Bit 7 low means auto-increment
          end
          default: ;
        endcase
      end

      // --------------------------------------------------
      // CPU accesses
      if (cpu_rd) begin
        case (cpu.port)
          PORT_VRAM: vram.rd_req <= ~vram_rd_ack;
          PORT_CTRL: first_byte <= 1'b1;  // Status read restarts pairing
          default: ;
        endcase
      end else if (cpu_wr) begin
        case (cpu.port)
          PORT_VRAM: begin
            vram.data   <= cpu.data;
            vram.wr_req <= ~vram_wr_ack;
          end
          PORT_CTRL: begin
            if (first_byte) begin
              first_byte <= 1'b0;
              p1_data    <= cpu.data;
            end else begin
              first_byte <= 1'b1;
              if (cpu.data[7]) begin
                // Direct register select
                reg_ptr      <= cpu.data[5:0];
                reg_wr_pulse <= 1'b1;
              end else begin
                vram.addr[7:0]    <= p1_data;
                vram.addr[13:8]   <= cpu.data[5:0];
                vram.addr_set_req <= ~vram_addr_set_ack;
                if (!cpu.data[6]) vram.rd_req <= ~vram_rd_ack;  // Read setup prefetches
              end
            end
          end
          PORT_INDIRECT: begin
            if (r17_num != `VDP_R17) reg_wr_pulse <= 1'b1;
            p1_data <= cpu.data;
            reg_ptr <= r17_num;
            if (r17_inc) r17_num <= 6'(r17_num + 6'd1);
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: source/vdp_register_top.sv
// VDP register block top level
// Port decoder feeding the control registers and palette, with the
// status read path combining their results for the CPU
`timescale 1ns/10ps
`include "vdp_defines.svh"

module vdp_register_top import vdp_pkg::*; (
  input  logic                      reset,
  input  logic                      clk21m,
  input  cpu_req_t                  cpu,
  output logic                      ack,
  output logic [`VDP_DATA_W-1:0]    rd_data,
  output vram_ctrl_t                vram,
  input  logic                      vram_wr_ack,
  input  logic                      vram_rd_ack,
  input  logic                      vram_addr_set_ack,
  input  logic [`VDP_DATA_W-1:0]    vram_rd_data,
  input  logic                      hsync,
  input  logic [1:0]                dotstate,
  input  logic [`VDP_PAL_IDX_W-1:0] pal_rd_idx,
  output pal_rgb_t                  pal_rgb,
  output ctrl_regs_t                regs,
  input  logic                      vsync_int_pending,
  input  logic                      hsync_int_pending,
  input  logic                      vert_retrace,
  input  logic                      horz_retrace,
  input  logic                      field,
  output logic                      clr_vsync_int,
  output logic                      clr_hsync_int
);

  reg_wr_t                  reg_wr;
  pal_wr_t                  pal_wr;
  logic [`VDP_STATUS_W-1:0] status_sel;
  logic                     hint_clr_wr;

  vdp_port_ctrl u_port_ctrl (
    .reset(reset), .clk21m(clk21m), .cpu(cpu),
    .vram_wr_ack(vram_wr_ack), .vram_rd_ack(vram_rd_ack),
    .vram_addr_set_ack(vram_addr_set_ack),
    .reg_wr(reg_wr), .pal_wr(pal_wr), .vram(vram),
    .status_sel(status_sel), .hint_clr_wr(hint_clr_wr)
  );

  vdp_ctrl_regs u_ctrl_regs (
    .reset(reset), .clk21m(clk21m), .reg_wr(reg_wr), .hsync(hsync), .regs(regs)
  );

  vdp_palette u_palette (
    .reset(reset), .clk21m(clk21m), .reg_wr(reg_wr), .pal_wr(pal_wr),
    .dotstate(dotstate), .pal_rd_idx(pal_rd_idx), .pal_rgb(pal_rgb)
  );

  vdp_status_read u_status_read (
    .reset(reset), .clk21m(clk21m), .cpu(cpu), .vram_rd_data(vram_rd_data),
    .status_sel(status_sel), .hint_clr_wr(hint_clr_wr),
    .vsync_int_pending(vsync_int_pending), .hsync_int_pending(hsync_int_pending),
    .vert_retrace(vert_retrace), .horz_retrace(horz_retrace), .field(field),
    .ack(ack), .rd_data(rd_data),
    .clr_vsync_int(clr_vsync_int), .clr_hsync_int(clr_hsync_int)
  );

endmodule

// File: source/vdp_status_read.sv
// VDP CPU read path
// Returns VRAM data or S#0..S#2, registers ack and generates the
// frame and line interrupt clear pulses
`timescale 1ns/10ps
`include "vdp_defines.svh"

module vdp_status_read import vdp_pkg::*; (
  input  logic                     reset,
  input  logic                     clk21m,
  input  cpu_req_t                 cpu,
  input  logic [`VDP_DATA_W-1:0]   vram_rd_data,
  input  logic [`VDP_STATUS_W-1:0] status_sel,
  input  logic                     hint_clr_wr,
  input  logic                     vsync_int_pending,
  input  logic                     hsync_int_pending,
  input  logic                     vert_retrace,
  input  logic                     horz_retrace,
  input  logic                     field,
  output logic                     ack,
  output logic [`VDP_DATA_W-1:0]   rd_data,
  output logic                     clr_vsync_int,
  output logic                     clr_hsync_int
);

  logic cpu_rd;
  logic stat_rd;    // Status read on port 1

  assign cpu_rd  = cpu.strobe & ~cpu.wr;
  assign stat_rd = cpu_rd && (cpu.port == PORT_CTRL);

  always_ff @(posedge reset or posedge clk21m) begin
    if (clk21m) begin
      ack           <= 1'b0;
      rd_data       <= '0;
      clr_vsync_int <= 1'b0;
      clr_hsync_int <= 1'b0;
    end else begin
      ack           <= cpu.strobe;
      clr_vsync_int <= stat_rd && (status_sel == `VDP_S0);
      clr_hsync_int <= (stat_rd && (status_sel == `VDP_S1)) || hint_clr_wr;
      if (cpu_rd) begin
        if (cpu.port == PORT_VRAM) begin
          rd_data <= vram_rd_data;
        end else if (cpu.port == PORT_CTRL) begin
          case (status_sel)
            `VDP_S0: rd_data <= {vsync_int_pending, 7'b0};
            `VDP_S1: rd_data <= {2'b00, `VDP_ID, hsync_int_pending};
            `VDP_S2: rd_data <= {1'b0, vert_retrace, horz_retrace, 1'b0,
                                 2'b11, field, 1'b0};  // Command bits fixed low
            default: rd_data <= 8'hFF;
          endcase
        end else begin
          rd_data <= 8'hFF;   // Ports 2 and 3 are write only
        end
      end
    end
  end

endmodule

// File: vdp_regs.f
+incdir+source
source/vdp_pkg.sv
source/vdp_port_ctrl.sv
source/vdp_ctrl_regs.sv
source/vdp_palette.sv
source/vdp_status_read.sv
source/vdp_register_top.sv
sim/vdp_register_assertions.sv
sim/vdp_register_tb.sv
